// ==== hdl/gfx_macros.svh ====
`ifndef GFX_MACROS_SVH
`define GFX_MACROS_SVH

// frame buffer geometry, 8 bits per pixel
`define GFX_PPL 16'd416
`define GFX_FB_BASE 32'h0002_0000

// 256-byte page of the register block, compared with adr[31:8]
`define GFX_REG_BASE 24'hFFDAE0

`endif

// ==== hdl/gfx_pkg.sv ====
package gfx_pkg;

	// command opcodes, written to register index 15
	typedef enum logic [7:0] {
		GFX_NOP        = 8'd0,
		GFX_DRAW_PIXEL = 8'd1,
		GFX_DRAW_LINE  = 8'd2,
		GFX_LINETO     = 8'd3,
		GFX_RECTANGLE  = 8'd4
	} gfx_cmd_e;

	// command sequencer
	typedef enum logic [1:0] {
		SEQ_IDLE,
		SEQ_LINE,
		SEQ_WAIT
	} seq_state_e;

	// bresenham line engine
	typedef enum logic [2:0] {
		LN_IDLE,
		LN_INIT,
		LN_PLOT,
		LN_WAIT,
		LN_STEP
	} line_state_e;

endpackage

// ==== hdl/gfx_regs.sv ====
`timescale 1ns/10ps
`include "gfx_macros.svh"

module gfx_regs import gfx_pkg::*; (
	input  logic        clk_i,
	input  logic        rst_i,
	input  logic        s_cyc_i,
	input  logic        s_stb_i,
	input  logic        s_we_i,
	input  logic [31:0] s_adr_i,
	input  logic [15:0] s_dat_i,
	input  logic        busy_i,
	output logic        s_ack_o,
	output logic [15:0] s_dat_o,
	output logic        cmd_stb_o,
	output gfx_cmd_e    cmd_op_o,
	output logic [15:0] x0_o,
	output logic [15:0] y0_o,
	output logic [15:0] x1_o,
	output logic [15:0] y1_o,
	output logic [7:0]  pen8_o
);

	logic       cs;
	logic [3:0] idx;

	assign cs = s_cyc_i && s_stb_i && (s_adr_i[31:8] == `GFX_REG_BASE);
	assign idx = s_adr_i[4:1];
	// zero wait state slave
	assign s_ack_o = cs;

	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			x0_o <= 16'd0;
			y0_o <= 16'd0;
			x1_o <= 16'd0;
			y1_o <= 16'd0;
			cmd_stb_o <= 1'b0;
		end else begin
			cmd_stb_o <= cs && s_we_i && (idx == 4'd15);
			if (cs && s_we_i) begin
				case (idx)
					4'd4: x0_o <= s_dat_i;
					4'd5: y0_o <= s_dat_i;
					4'd6: x1_o <= s_dat_i;
					4'd7: y1_o <= s_dat_i;
					default: ;
				endcase
			end
		end
	end

	// 3-3-2 colour taken from the 32-bit pen value
	always_ff @(posedge clk_i) begin
		if (cs && s_we_i && idx == 4'd0)
			pen8_o[7:5] <= s_dat_i[7:5];
		if (cs && s_we_i && idx == 4'd1) begin
			pen8_o[4:2] <= s_dat_i[15:13];
			pen8_o[1:0] <= s_dat_i[7:6];
		end
		if (cs && s_we_i && idx == 4'd15)
			cmd_op_o <= gfx_cmd_e'(s_dat_i[7:0]);
	end

	always_comb begin
		case (idx)
			4'd4: s_dat_o = x0_o;
			4'd5: s_dat_o = y0_o;
			4'd6: s_dat_o = x1_o;
			4'd7: s_dat_o = y1_o;
			4'd15: s_dat_o = {15'd0, busy_i};
			default: s_dat_o = 16'd0;
		endcase
	end

endmodule

// ==== hdl/gfx_cmd_seq.sv ====
`timescale 1ns/10ps

module gfx_cmd_seq import gfx_pkg::*; (
	input  logic        clk_i,
	input  logic        rst_i,
	input  logic        cmd_stb_i,
	input  gfx_cmd_e    cmd_op_i,
	input  logic [15:0] x0_i,
	input  logic [15:0] y0_i,
	input  logic [15:0] x1_i,
	input  logic [15:0] y1_i,
	input  logic        line_done_i,
	output logic        busy_o,
	output logic        line_start_o,
	output logic [15:0] lx0_o,
	output logic [15:0] ly0_o,
	output logic [15:0] lx1_o,
	output logic [15:0] ly1_o
);

	seq_state_e  state;
	gfx_cmd_e    op;
	logic [1:0]  edge_cnt;
	logic [15:0] rx0, ry0, rx1, ry1;
	logic [15:0] cur_x, cur_y;
	logic        draw_op;

	assign draw_op = (cmd_op_i == GFX_DRAW_PIXEL) || (cmd_op_i == GFX_DRAW_LINE) ||
		(cmd_op_i == GFX_LINETO) || (cmd_op_i == GFX_RECTANGLE);

	assign busy_o = (state != SEQ_IDLE);
	assign line_start_o = (state == SEQ_LINE);

	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			state <= SEQ_IDLE;
			edge_cnt <= 2'd0;
			cur_x <= 16'd0;
			cur_y <= 16'd0;
		end else begin
			case (state)
				SEQ_IDLE: begin
					// nop and unknown opcodes fall through here
					if (cmd_stb_i && draw_op) begin
						state <= SEQ_LINE;
						edge_cnt <= 2'd0;
					end
				end
				SEQ_LINE: state <= SEQ_WAIT;
				SEQ_WAIT: begin
					if (line_done_i) begin
						cur_x <= lx1_o;
						cur_y <= ly1_o;
						if (op == GFX_RECTANGLE && edge_cnt != 2'd3) begin
							edge_cnt <= edge_cnt + 2'd1;
							state <= SEQ_LINE;
						end else begin
							state <= SEQ_IDLE;
						end
					end
				end
				default: state <= SEQ_IDLE;
			endcase
		end
	end

	// job end points and latched corners
	always_ff @(posedge clk_i) begin
		if (state == SEQ_IDLE && cmd_stb_i && draw_op) begin
			op <= cmd_op_i;
			rx0 <= x0_i;
			ry0 <= y0_i;
			rx1 <= x1_i;
			ry1 <= y1_i;
			case (cmd_op_i)
				GFX_DRAW_PIXEL: {lx0_o, ly0_o, lx1_o, ly1_o} <= {x0_i, y0_i, x0_i, y0_i};
				GFX_LINETO: {lx0_o, ly0_o, lx1_o, ly1_o} <= {cur_x, cur_y, x0_i, y0_i};
				GFX_RECTANGLE: {lx0_o, ly0_o, lx1_o, ly1_o} <= {x0_i, y0_i, x1_i, y0_i};
				default: {lx0_o, ly0_o, lx1_o, ly1_o} <= {x0_i, y0_i, x1_i, y1_i};
			endcase
		end else if (state == SEQ_WAIT && line_done_i && op == GFX_RECTANGLE) begin
			// next edge follows the one just finished
			case (edge_cnt)
				2'd0: {lx0_o, ly0_o, lx1_o, ly1_o} <= {rx1, ry0, rx1, ry1};
				2'd1: {lx0_o, ly0_o, lx1_o, ly1_o} <= {rx1, ry1, rx0, ry1};
				2'd2: {lx0_o, ly0_o, lx1_o, ly1_o} <= {rx0, ry1, rx0, ry0};
				default: ;
			endcase
		end
	end

endmodule

// ==== hdl/gfx_line_engine.sv ====
`timescale 1ns/10ps

module gfx_line_engine import gfx_pkg::*; (
	input  logic        clk_i,
	input  logic        rst_i,
	input  logic        line_start_i,
	input  logic [15:0] lx0_i,
	input  logic [15:0] ly0_i,
	input  logic [15:0] lx1_i,
	input  logic [15:0] ly1_i,
	input  logic        pix_done_i,
	output logic        pix_req_o,
	output logic [15:0] px_o,
	output logic [15:0] py_o,
	output logic        line_done_o
);

	line_state_e        state;
	logic signed [15:0] dx, dy;
	logic signed [15:0] sx, sy;
	logic signed [15:0] err;
	logic signed [15:0] e2;
	logic signed [15:0] dx_c, dy_c;
	logic               at_end;
	logic               step_x, step_y;

	// absolute deltas from the held end points
	assign dx_c = $signed((lx1_i < lx0_i) ? lx0_i - lx1_i : lx1_i - lx0_i);
	assign dy_c = $signed((ly1_i < ly0_i) ? ly0_i - ly1_i : ly1_i - ly0_i);

	assign e2 = err <<< 1;
	assign step_x = (e2 > -dy);
	assign step_y = (e2 < dx);
	assign at_end = (px_o == lx1_i) && (py_o == ly1_i);

	assign pix_req_o = (state == LN_PLOT);

	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			state <= LN_IDLE;
			line_done_o <= 1'b0;
		end else begin
			line_done_o <= 1'b0;
			case (state)
				LN_IDLE: if (line_start_i) state <= LN_INIT;
				LN_INIT: state <= LN_PLOT;
				LN_PLOT: state <= LN_WAIT;
				LN_WAIT: begin
					if (pix_done_i) begin
						if (at_end) begin
							line_done_o <= 1'b1;
							state <= LN_IDLE;
						end else begin
							state <= LN_STEP;
						end
					end
				end
				LN_STEP: state <= LN_PLOT;
				default: state <= LN_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk_i) begin
		if (state == LN_INIT) begin
			px_o <= lx0_i;
			py_o <= ly0_i;
			dx <= dx_c;
			dy <= dy_c;
			sx <= (lx0_i < lx1_i) ? 16'sd1 : -16'sd1;
			sy <= (ly0_i < ly1_i) ? 16'sd1 : -16'sd1;
			err <= dx_c - dy_c;
		end else if (state == LN_STEP) begin
			// both axes may move on a diagonal step
			err <= err - (step_x ? dy : 16'sd0) + (step_y ? dx : 16'sd0);
			if (step_x)
				px_o <= px_o + 16'(sx);
			if (step_y)
				py_o <= py_o + 16'(sy);
		end
	end

endmodule

// ==== hdl/gfx_pixel_writer.sv ====
`timescale 1ns/10ps
`include "gfx_macros.svh"

module gfx_pixel_writer (
	input  logic        clk_i,
	input  logic        rst_i,
	input  logic        pix_req_i,
	input  logic [15:0] px_i,
	input  logic [15:0] py_i,
	input  logic [7:0]  pen8_i,
	input  logic        m_ack_i,
	output logic        m_cyc_o,
	output logic        m_stb_o,
	output logic        m_we_o,
	output logic [1:0]  m_sel_o,
	output logic [31:0] m_adr_o,
	output logic [15:0] m_dat_o,
	output logic        pix_done_o
);

	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			m_cyc_o <= 1'b0;
			m_stb_o <= 1'b0;
			m_we_o <= 1'b0;
			m_sel_o <= 2'b00;
			pix_done_o <= 1'b0;
		end else begin
			pix_done_o <= m_cyc_o && m_ack_i;
			if (!m_cyc_o && pix_req_i) begin
				m_cyc_o <= 1'b1;
				m_stb_o <= 1'b1;
				m_we_o <= 1'b1;
				// odd pixel in the upper byte lane
				m_sel_o <= {px_i[0], ~px_i[0]};
			end else if (m_cyc_o && m_ack_i) begin
				m_cyc_o <= 1'b0;
				m_stb_o <= 1'b0;
				m_we_o <= 1'b0;
				m_sel_o <= 2'b00;
			end
		end
	end

	// address and data are loaded with the request and held for the cycle
	always_ff @(posedge clk_i) begin
		if (!m_cyc_o && pix_req_i) begin
			m_adr_o <= `GFX_FB_BASE + 32'(py_i) * 32'(`GFX_PPL) + 32'(px_i);
			m_dat_o <= {2{pen8_i}};
		end
	end

endmodule

// ==== hdl/gfx_accel.sv ====
`timescale 1ns/10ps

module gfx_accel import gfx_pkg::*; (
	input  logic        clk_i,
	input  logic        rst_i,
	// slave port, registers are always written as whole words
	input  logic        s_cyc_i,
	input  logic        s_stb_i,
	input  logic        s_we_i,
	input  logic [1:0]  s_sel_i,
	input  logic [31:0] s_adr_i,
	input  logic [15:0] s_dat_i,
	output logic [15:0] s_dat_o,
	output logic        s_ack_o,
	// master port to the frame buffer
	output logic        m_cyc_o,
	output logic        m_stb_o,
	output logic        m_we_o,
	output logic [1:0]  m_sel_o,
	output logic [31:0] m_adr_o,
	output logic [15:0] m_dat_o,
	input  logic        m_ack_i
);

	logic        busy;
	logic        cmd_stb;
	gfx_cmd_e    cmd_op;
	logic [15:0] x0, y0, x1, y1;
	logic [7:0]  pen8;
	logic        line_start, line_done;
	logic [15:0] lx0, ly0, lx1, ly1;
	logic        pix_req, pix_done;
	logic [15:0] px, py;

	gfx_regs gfx_regs_inst (
		.clk_i(clk_i), .rst_i(rst_i),
		.s_cyc_i(s_cyc_i), .s_stb_i(s_stb_i), .s_we_i(s_we_i),
		.s_adr_i(s_adr_i), .s_dat_i(s_dat_i), .busy_i(busy),
		.s_ack_o(s_ack_o), .s_dat_o(s_dat_o),
		.cmd_stb_o(cmd_stb), .cmd_op_o(cmd_op),
		.x0_o(x0), .y0_o(y0), .x1_o(x1), .y1_o(y1), .pen8_o(pen8)
	);

	gfx_cmd_seq gfx_cmd_seq_inst (
		.clk_i(clk_i), .rst_i(rst_i),
		.cmd_stb_i(cmd_stb), .cmd_op_i(cmd_op),
		.x0_i(x0), .y0_i(y0), .x1_i(x1), .y1_i(y1),
		.line_done_i(line_done), .busy_o(busy), .line_start_o(line_start),
		.lx0_o(lx0), .ly0_o(ly0), .lx1_o(lx1), .ly1_o(ly1)
	);

	gfx_line_engine gfx_line_engine_inst (
		.clk_i(clk_i), .rst_i(rst_i), .line_start_i(line_start),
		.lx0_i(lx0), .ly0_i(ly0), .lx1_i(lx1), .ly1_i(ly1),
		.pix_done_i(pix_done), .pix_req_o(pix_req),
		.px_o(px), .py_o(py), .line_done_o(line_done)
	);

	gfx_pixel_writer gfx_pixel_writer_inst (
		.clk_i(clk_i), .rst_i(rst_i), .pix_req_i(pix_req),
		.px_i(px), .py_i(py), .pen8_i(pen8), .m_ack_i(m_ack_i),
		.m_cyc_o(m_cyc_o), .m_stb_o(m_stb_o), .m_we_o(m_we_o), .m_sel_o(m_sel_o),
		.m_adr_o(m_adr_o), .m_dat_o(m_dat_o), .pix_done_o(pix_done)
	);

endmodule

// ==== sim/gfx_accel_properties.sv ====
`timescale 1ns/10ps

module gfx_accel_properties (
	input logic        clk_i,
	input logic        rst_i,
	input logic        m_cyc_i,
	input logic        m_stb_i,
	input logic        m_ack_i,
	input logic [1:0]  m_sel_i,
	input logic [31:0] m_adr_i,
	input logic [15:0] m_dat_i,
	input logic        pix_req_i,
	input logic        line_done_i
);

	int fail_cnt = 0;

	assert property (@(posedge clk_i) disable iff (rst_i) m_stb_i == m_cyc_i)
		else begin
			fail_cnt++;
			$error("m_stb_o differs from m_cyc_o");
		end

	// a write waiting for its ack keeps address, lanes and data
	assert property (@(posedge clk_i) disable iff (rst_i)
		m_cyc_i && !m_ack_i |=> $stable({m_adr_i, m_sel_i, m_dat_i}))
		else begin
			fail_cnt++;
			$error("master bus changed while waiting for m_ack_i");
		end

	assert property (@(posedge clk_i) disable iff (rst_i) pix_req_i |-> !m_cyc_i)
		else begin
			fail_cnt++;
			$error("pixel request while a bus cycle is open");
		end

	assert property (@(posedge clk_i) disable iff (rst_i) line_done_i |=> !line_done_i)
		else begin
			fail_cnt++;
			$error("line_done longer than one cycle");
		end

endmodule

// pixel writer bus and line engine handshake seen from the top level
bind gfx_accel gfx_accel_properties gfx_accel_properties_inst (
	.clk_i(clk_i), .rst_i(rst_i),
	.m_cyc_i(m_cyc_o), .m_stb_i(m_stb_o), .m_ack_i(m_ack_i),
	.m_sel_i(m_sel_o), .m_adr_i(m_adr_o), .m_dat_i(m_dat_o),
	.pix_req_i(pix_req), .line_done_i(line_done)
);

// ==== sim/gfx_accel_tb.sv ====
`timescale 1ns/10ps
`include "gfx_macros.svh"

module gfx_accel_tb import gfx_pkg::*; ();

	typedef struct packed {
		logic [31:0] pen;
		logic [15:0] x0;
		logic [15:0] y0;
		logic [15:0] x1;
		logic [15:0] y1;
		gfx_cmd_e    op;
		logic        busy_cmd;
	} row_t;

	logic        clk_i;
	logic        rst_i;
	logic        s_cyc_i, s_stb_i, s_we_i;
	logic [1:0]  s_sel_i;
	logic [31:0] s_adr_i;
	logic [15:0] s_dat_i;
	logic [15:0] s_dat_o;
	logic        s_ack_o;
	logic        m_cyc_o, m_stb_o, m_we_o;
	logic [1:0]  m_sel_o;
	logic [31:0] m_adr_o;
	logic [15:0] m_dat_o;
	logic        m_ack_i;

	row_t        rows[$];
	// expected writes as {address, select, data}
	logic [49:0] exp_q[$];
	logic [31:0] rng;
	logic [15:0] cur_x, cur_y;
	int          errors;
	int          cycles;
	int          limit;
	int          ack_delay;

	gfx_accel gfx_accel_inst (.*);

	always #20 clk_i = ~clk_i;

	function automatic logic [31:0] xorshift(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	task automatic check(input string name, input logic [31:0] got, input logic [31:0] want);
		if (got !== want) begin
			errors++;
			$display("Fail %s: got 0x%0h, expected 0x%0h", name, got, want);
		end
	endtask

	// reference bresenham with one expected write per point
	task automatic model_line(input logic [15:0] x0, y0, x1, y1, input logic [7:0] pen8);
		int x, y, dx, dy, sx, sy, err, e2;
		x = x0;
		y = y0;
		dx = (x1 > x0) ? x1 - x0 : x0 - x1;
		dy = (y1 > y0) ? y1 - y0 : y0 - y1;
		sx = (x0 < x1) ? 1 : -1;
		sy = (y0 < y1) ? 1 : -1;
		err = dx - dy;
		forever begin
			exp_q.push_back({`GFX_FB_BASE + y * `GFX_PPL + x,
				(x % 2) ? 2'b10 : 2'b01, pen8, pen8});
			if (x == x1 && y == y1)
				break;
			e2 = 2 * err;
			if (e2 > -dy) begin
				err = err - dy;
				x = x + sx;
			end
			if (e2 < dx) begin
				err = err + dx;
				y = y + sy;
			end
		end
		cur_x = x1;
		cur_y = y1;
	endtask

	task automatic model_command(input row_t r);
		logic [7:0] pen8;
		pen8 = {r.pen[23:21], r.pen[15:13], r.pen[7:6]};
		case (r.op)
			GFX_DRAW_PIXEL: model_line(r.x0, r.y0, r.x0, r.y0, pen8);
			GFX_DRAW_LINE: model_line(r.x0, r.y0, r.x1, r.y1, pen8);
			GFX_LINETO: model_line(cur_x, cur_y, r.x0, r.y0, pen8);
			GFX_RECTANGLE: begin
				model_line(r.x0, r.y0, r.x1, r.y0, pen8);
				model_line(r.x1, r.y0, r.x1, r.y1, pen8);
				model_line(r.x1, r.y1, r.x0, r.y1, pen8);
				model_line(r.x0, r.y1, r.x0, r.y0, pen8);
			end
			default: ;
		endcase
	endtask

	task automatic reg_write(input logic [3:0] idx, input logic [15:0] dat);
		@(posedge clk_i);
		s_cyc_i <= 1'b1;
		s_stb_i <= 1'b1;
		s_we_i <= 1'b1;
		s_adr_i <= {`GFX_REG_BASE, 3'b000, idx, 1'b0};
		s_dat_i <= dat;
		@(posedge clk_i);
		s_cyc_i <= 1'b0;
		s_stb_i <= 1'b0;
		s_we_i <= 1'b0;
	endtask

	task automatic reg_read(input logic [3:0] idx, output logic [15:0] dat);
		@(posedge clk_i);
		s_cyc_i <= 1'b1;
		s_stb_i <= 1'b1;
		s_we_i <= 1'b0;
		s_adr_i <= {`GFX_REG_BASE, 3'b000, idx, 1'b0};
		@(negedge clk_i);
		if (!s_ack_o) begin
			errors++;
			$display("register read at index %0d was not acknowledged", idx);
		end
		dat = s_dat_o;
		@(posedge clk_i);
		s_cyc_i <= 1'b0;
		s_stb_i <= 1'b0;
	endtask

	// frame buffer slave with 0 to 3 cycles of ack delay
	always @(posedge clk_i) begin
		logic [49:0] want;
		if (rst_i) begin
			m_ack_i <= 1'b0;
			ack_delay = -1;
		end else begin
			m_ack_i <= 1'b0;
			if (m_cyc_o && !m_ack_i) begin
				if (ack_delay < 0) begin
					rng = xorshift(rng);
					ack_delay = rng[1:0];
				end
				if (ack_delay == 0) begin
					m_ack_i <= 1'b1;
					ack_delay = -1;
					if (exp_q.size() == 0) begin
						errors++;
						$display("unexpected frame buffer write at address 0x%0h", m_adr_o);
					end else begin
						want = exp_q.pop_front();
						check("m_adr_o", m_adr_o, want[49:18]);
						check("m_sel_o", m_sel_o, want[17:16]);
						check("m_dat_o", m_dat_o, want[15:0]);
						check("m_we_o", m_we_o, 1);
						check("m_stb_o", m_stb_o, 1);
					end
				end else begin
					ack_delay = ack_delay - 1;
				end
			end
		end
	end

	always @(posedge clk_i) begin
		cycles = cycles + 1;
		if (cycles > limit) begin
			$display("run stopped after %0d cycles without finishing, %0d errors", limit, errors);
			$display("TEST RESULT: FAIL");
			$finish;
		end
	end

	initial begin
		logic [15:0] rd;
		clk_i = 1'b0;
		rst_i = 1'b1;
		s_cyc_i = 1'b0;
		s_stb_i = 1'b0;
		s_we_i = 1'b0;
		s_sel_i = 2'b11;
		s_adr_i = 32'd0;
		s_dat_i = 16'd0;
		m_ack_i = 1'b0;
		rng = 32'h45cb;
		errors = 0;
		cycles = 0;
		// pen, x0, y0, x1, y1, opcode, extra command while busy
		rows.push_back(row_t'{32'h00A0_6040, 5, 3, 0, 0, GFX_DRAW_PIXEL, 0});
		rows.push_back(row_t'{32'h0040_A080, 8, 2, 0, 0, GFX_DRAW_PIXEL, 0});
		rows.push_back(row_t'{32'h00E0_1F3F, 2, 10, 12, 10, GFX_DRAW_LINE, 0});
		rows.push_back(row_t'{32'h1234_5678, 14, 11, 3, 11, GFX_DRAW_LINE, 0});
		rows.push_back(row_t'{32'h00FF_FFFF, 20, 1, 20, 9, GFX_DRAW_LINE, 0});
		rows.push_back(row_t'{32'hFF1F_E03F, 21, 9, 21, 0, GFX_DRAW_LINE, 0});
		rows.push_back(row_t'{32'h0060_C0C0, 0, 0, 11, 4, GFX_DRAW_LINE, 0});
		rows.push_back(row_t'{32'h00A0_6040, 30, 20, 18, 15, GFX_DRAW_LINE, 0});
		rows.push_back(row_t'{32'h00C0_2080, 40, 20, 43, 5, GFX_DRAW_LINE, 0});
		rows.push_back(row_t'{32'h0020_8040, 50, 2, 45, 14, GFX_DRAW_LINE, 0});
		rows.push_back(row_t'{32'h0080_40C0, 60, 30, 0, 0, GFX_LINETO, 0});
		rows.push_back(row_t'{32'h0080_40C0, 55, 35, 0, 0, GFX_LINETO, 0});
		rows.push_back(row_t'{32'h00E0_E0C0, 100, 50, 110, 56, GFX_RECTANGLE, 0});
		rows.push_back(row_t'{32'h0040_2040, 120, 70, 115, 66, GFX_RECTANGLE, 0});
		rows.push_back(row_t'{32'h0040_2040, 1, 1, 2, 2, GFX_NOP, 0});
		rows.push_back(row_t'{32'h00A0_A080, 200, 100, 209, 104, GFX_DRAW_LINE, 1});
		rows.push_back(row_t'{32'h0060_6040, 400, 3, 0, 0, GFX_LINETO, 1});
		rows.push_back(row_t'{32'h0020_C000, 415, 479, 0, 0, GFX_DRAW_PIXEL, 0});

		// dry run of the model sizes the cycle limit
		cur_x = 16'd0;
		cur_y = 16'd0;
		foreach (rows[i])
			model_command(rows[i]);
		limit = 64 * exp_q.size() + 200 * rows.size();
		exp_q.delete();
		cur_x = 16'd0;
		cur_y = 16'd0;

		repeat (2) @(posedge clk_i);
		rst_i <= 1'b0;

		foreach (rows[i]) begin
			reg_write(4'd0, rows[i].pen[31:16]);
			reg_write(4'd1, rows[i].pen[15:0]);
			reg_write(4'd4, rows[i].x0);
			reg_write(4'd5, rows[i].y0);
			reg_write(4'd6, rows[i].x1);
			reg_write(4'd7, rows[i].y1);
			reg_read(4'd4, rd);
			check("s_dat_o x0", rd, rows[i].x0);
			reg_read(4'd5, rd);
			check("s_dat_o y0", rd, rows[i].y0);
			reg_read(4'd6, rd);
			check("s_dat_o x1", rd, rows[i].x1);
			reg_read(4'd7, rd);
			check("s_dat_o y1", rd, rows[i].y1);
			model_command(rows[i]);
			reg_write(4'd15, {8'd0, rows[i].op});
			if (rows[i].busy_cmd) begin
				reg_read(4'd15, rd);
				check("s_dat_o busy", rd, 1);
				// dropped by the busy sequencer and not modeled
				reg_write(4'd15, {8'd0, GFX_DRAW_LINE});
			end
			do
				reg_read(4'd15, rd);
			while (rd[0]);
			if (exp_q.size() != 0) begin
				errors++;
				$display("row %0d finished with %0d expected writes missing", i, exp_q.size());
				exp_q.delete();
			end
		end

		errors = errors + gfx_accel_inst.gfx_accel_properties_inst.fail_cnt;
		$display("%0d errors in %0d rows, %0d cycles", errors, rows.size(), cycles);
		if (errors == 0)
			$display("TEST RESULT: PASS");
		else
			$display("TEST RESULT: FAIL");
		$finish;
	end

endmodule

// ==== gfx_accel.f ====
+incdir+hdl
hdl/gfx_pkg.sv
hdl/gfx_regs.sv
hdl/gfx_cmd_seq.sv
hdl/gfx_line_engine.sv
hdl/gfx_pixel_writer.sv
hdl/gfx_accel.sv
sim/gfx_accel_properties.sv
sim/gfx_accel_tb.sv
